/* src/gray_pkg.sv */
// Gray position decoder shared definitions
// Prefix structure selector and the sizes used across the design
// and by the receiver model on the output link

package gray_pkg;

	// Sensor word
	localparam int WIDTH = 12; // Gray sample width in bits
	localparam int PREFIX_LEVELS = $clog2(WIDTH); // Depth of a log prefix tree

	// Output link
	localparam int CREDITS = 4; // Receiver buffer slots
	localparam int CREDIT_W = $clog2(CREDITS + 1); // Holds 0 to CREDITS

	// Internal sample queue
	localparam int QUEUE_DEPTH = 4;
	localparam int QUEUE_PTR_W = $clog2(QUEUE_DEPTH); // Read and write pointers
	localparam int QUEUE_CNT_W = $clog2(QUEUE_DEPTH + 1); // Fill level up to full

	// Area versus depth of the prefix XOR network
	typedef enum logic [1:0] {
		SLOW   = 2'b00, // Serial chain
		MEDIUM = 2'b01, // Brent-Kung
		FAST   = 2'b10  // Sklansky
	} speed_e;

endpackage

/* src/sample_if.sv */
// Decoded sample channel from position tracker to credit sender
// Valid/ready handshake, one sample moves when both are high

interface sample_if;

	logic valid; // Sample held by tracker
	logic ready; // Queue has room
	logic [gray_pkg::WIDTH-1:0] position; // Binary position
	logic signed [gray_pkg::WIDTH-1:0] delta; // Movement since last sample
	logic glitch; // More than one Gray bit changed

	modport producer (
		output valid, position, delta, glitch,
		input  ready
	);

	modport consumer (
		input  valid, position, delta, glitch,
		output ready
	);

endinterface

/* src/gray_to_bin.sv */
// Gray to binary converter
// Each binary bit is the XOR of all Gray bits at or above it. This is a
// prefix XOR over the bit reversed word, built as Sklansky, Brent-Kung
// or a serial chain depending on speed. Purely combinational

module gray_to_bin #(
	parameter gray_pkg::speed_e speed = gray_pkg::FAST // Prefix structure
) (
	input  logic [gray_pkg::WIDTH-1:0] gray,
	output logic [gray_pkg::WIDTH-1:0] bin
);

	logic [gray_pkg::WIDTH-1:0] gray_rev; // MSB now at bit 0
	logic [gray_pkg::WIDTH-1:0] bin_rev;  // Prefix XOR result, still reversed

	// Reverse in and out around the prefix network
	for (genvar i = 0; i < gray_pkg::WIDTH; i++) begin : g_rev
		assign gray_rev[i] = gray[gray_pkg::WIDTH-1-i];
		assign bin[i] = bin_rev[gray_pkg::WIDTH-1-i];
	end

	if (speed == gray_pkg::FAST) begin : g_sklansky
		// Row l holds the network after level l
		logic [gray_pkg::PREFIX_LEVELS:0][gray_pkg::WIDTH-1:0] pt;

		assign pt[0] = gray_rev;

		for (genvar l = 1; l <= gray_pkg::PREFIX_LEVELS; l++) begin : g_level
			for (genvar i = 0; i < gray_pkg::WIDTH; i++) begin : g_bit
				if ((i / 2**(l-1)) % 2 == 1) begin : g_black
					// Upper half of a block takes the last bit of the lower half
					assign pt[l][i] = pt[l-1][i]
						^ pt[l-1][(i / 2**(l-1)) * 2**(l-1) - 1];
				end else begin : g_white
					assign pt[l][i] = pt[l-1][i]; // Pass through
				end
			end
		end

		assign bin_rev = pt[gray_pkg::PREFIX_LEVELS];

	end else if (speed == gray_pkg::MEDIUM) begin : g_brent_kung
		// Up-sweep rows 1..L then down-sweep rows L+1..2L-1
		logic [2*gray_pkg::PREFIX_LEVELS-1:0][gray_pkg::WIDTH-1:0] pt;

		assign pt[0] = gray_rev;

		// Block sums land on the last bit of each 2**l block
		for (genvar l = 1; l <= gray_pkg::PREFIX_LEVELS; l++) begin : g_up
			for (genvar i = 0; i < gray_pkg::WIDTH; i++) begin : g_bit
				if ((i + 1) % 2**l == 0) begin : g_black
					assign pt[l][i] = pt[l-1][i] ^ pt[l-1][i - 2**(l-1)];
				end else begin : g_white
					assign pt[l][i] = pt[l-1][i];
				end
			end
		end

		// Fill in the middle bits with shrinking distance
		for (genvar r = gray_pkg::PREFIX_LEVELS + 1; r < 2*gray_pkg::PREFIX_LEVELS;
				r++) begin : g_down
			for (genvar i = 0; i < gray_pkg::WIDTH; i++) begin : g_bit
				if ((i + 1) % 2**(2*gray_pkg::PREFIX_LEVELS - r)
						== 2**(2*gray_pkg::PREFIX_LEVELS - r - 1)
						&& i >= 2**(2*gray_pkg::PREFIX_LEVELS - r)) begin : g_black
					assign pt[r][i] = pt[r-1][i]
						^ pt[r-1][i - 2**(2*gray_pkg::PREFIX_LEVELS - r - 1)];
				end else begin : g_white
					assign pt[r][i] = pt[r-1][i];
				end
			end
		end

		assign bin_rev = pt[2*gray_pkg::PREFIX_LEVELS-1];

	end else begin : g_serial
		logic [gray_pkg::WIDTH-1:0] pt; // Ripple chain, WIDTH-1 gates deep

		assign pt[0] = gray_rev[0];
		for (genvar i = 1; i < gray_pkg::WIDTH; i++) begin : g_bit
			assign pt[i] = pt[i-1] ^ gray_rev[i];
		end

		assign bin_rev = pt;
	end

endmodule

/* src/position_tracker.sv */
// Position tracker
// Accepts one Gray word per handshake, converts it to binary and
// registers position, signed delta to the previous word and a glitch
// flag for multi-bit Gray changes. One register stage to the sample

module position_tracker #(
	parameter gray_pkg::speed_e speed = gray_pkg::FAST
) (
	input  logic clk,
	input  logic rst_n,
	input  logic in_valid,
	input  logic [gray_pkg::WIDTH-1:0] in_gray,
	output logic in_ready,
	sample_if.producer smp
);

	logic [gray_pkg::WIDTH-1:0] bin_now;   // Converted input word
	logic [gray_pkg::WIDTH-1:0] prev_gray; // Last accepted Gray word
	logic [gray_pkg::WIDTH-1:0] gray_diff; // Changed Gray bits
	logic have_prev; // A word was accepted since reset
	logic accept;

	gray_to_bin #(
		.speed(speed)
	) i_conv (
		.gray(in_gray),
		.bin (bin_now)
	);

	// Output register empty or draining this cycle
	assign in_ready = !smp.valid || smp.ready;
	assign accept = in_valid && in_ready;
	assign gray_diff = in_gray ^ prev_gray;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			smp.valid <= 1'b0;
			have_prev <= 1'b0;
		end else begin
			if (accept) begin
				smp.valid <= 1'b1;
				have_prev <= 1'b1;
			end else if (smp.ready) begin
				smp.valid <= 1'b0; // Taken by sender
			end
		end
	end

	// Payload and history
	// smp.position doubles as the previous position
	always_ff @(posedge clk) begin
		if (accept) begin
			smp.position <= bin_now;
			smp.delta <= have_prev ? bin_now - smp.position : '0; // Wraps mod 2**WIDTH
			// x & (x-1) clears the lowest set bit, so nonzero means two or more
			smp.glitch <= have_prev && ((gray_diff & (gray_diff - 1'b1)) != '0);
			prev_gray <= in_gray;
		end
	end

	// Held sample must not change until the sender takes it
	a_hold_stable: assert property (@(posedge clk) disable iff (!rst_n)
		smp.valid && !smp.ready |=> smp.valid && $stable(smp.position)
			&& $stable(smp.delta) && $stable(smp.glitch));

endmodule

/* src/credit_sender.sv */
// Credit sender
// Queues decoded samples and sends them on the output link, one
// out_valid pulse per sample, only while receiver credits remain.
// credit_return restores one credit per freed receiver slot

module credit_sender (
	input  logic clk,
	input  logic rst_n,
	sample_if.consumer smp,
	input  logic credit_return,
	output logic out_valid,
	output logic [gray_pkg::WIDTH-1:0] out_position,
	output logic signed [gray_pkg::WIDTH-1:0] out_delta,
	output logic out_glitch
);

	logic [2*gray_pkg::WIDTH:0] mem [gray_pkg::QUEUE_DEPTH]; // {glitch, delta, position}
	logic [gray_pkg::QUEUE_PTR_W-1:0] wr_ptr;
	logic [gray_pkg::QUEUE_PTR_W-1:0] rd_ptr;
	logic [gray_pkg::QUEUE_CNT_W-1:0] count; // Queue fill level
	logic [gray_pkg::CREDIT_W-1:0] credits;  // Free receiver slots
	logic push;
	logic pop;

	assign smp.ready = count != gray_pkg::QUEUE_DEPTH; // Low only when full
	assign push = smp.valid && smp.ready;
	assign pop = (count != '0) && (credits != '0); // Send head whenever allowed

	// Head of queue straight onto the link
	assign out_valid = pop;
	assign {out_glitch, out_delta, out_position} = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (push) begin
			mem[wr_ptr] <= {smp.glitch, smp.delta, smp.position};
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			credits <= gray_pkg::CREDIT_W'(gray_pkg::CREDITS); // Receiver starts empty
		end else begin
			if (push) begin
				wr_ptr <= (wr_ptr == gray_pkg::QUEUE_DEPTH - 1) ? '0 : wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= (rd_ptr == gray_pkg::QUEUE_DEPTH - 1) ? '0 : rd_ptr + 1'b1;
			end
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count; // Both or neither
			endcase
			case ({pop, credit_return}) // Spend and return may coincide
				2'b10: credits <= credits - 1'b1;
				2'b01: credits <= credits + 1'b1;
				default: credits <= credits;
			endcase
		end
	end

	// Receiver never returns more than it was sent
	a_credit_max: assert property (@(posedge clk) disable iff (!rst_n)
		credits <= gray_pkg::CREDITS);

	// Last credit spent and none back, so the link goes quiet
	a_no_send_empty: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid && credits == 1 && !credit_return |=> !out_valid);

	// Fill level beyond depth means a push into a full queue
	a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
		count <= gray_pkg::QUEUE_DEPTH);

endmodule

/* src/gray_decoder_top.sv */
// Gray-coded absolute position decoder
// Valid/ready sensor input, tracker and credit based output link.
// Minimum latency of two cycles from input accept to out_valid

module gray_decoder_top #(
	parameter gray_pkg::speed_e speed = gray_pkg::FAST // Converter structure
) (
	input  logic clk,
	input  logic rst_n,
	input  logic in_valid,
	input  logic [gray_pkg::WIDTH-1:0] in_gray,
	output logic in_ready,
	input  logic credit_return,
	output logic out_valid,
	output logic [gray_pkg::WIDTH-1:0] out_position,
	output logic signed [gray_pkg::WIDTH-1:0] out_delta,
	output logic out_glitch
);

	sample_if smp (); // Tracker to sender

	position_tracker #(
		.speed(speed)
	) i_tracker (
		.clk     (clk),
		.rst_n   (rst_n),
		.in_valid(in_valid),
		.in_gray (in_gray),
		.in_ready(in_ready),
		.smp     (smp)
	);

	credit_sender i_sender (
		.clk          (clk),
		.rst_n        (rst_n),
		.smp          (smp),
		.credit_return(credit_return),
		.out_valid    (out_valid),
		.out_position (out_position),
		.out_delta    (out_delta),
		.out_glitch   (out_glitch)
	);

endmodule

/* dv/gray_decoder_tb.sv */
// Testbench for the Gray position decoder
// Feeds Gray words from the pattern file with random gaps, models the
// credit receiver on the output link and checks every sample in order.
// Credits are withheld at the start until in_ready drops

module gray_decoder_tb;

	localparam int W = gray_pkg::WIDTH;
	localparam int CLK_PERIOD = 40;
	localparam int RESET_CYCLES = 8;
	localparam int N_PAT = 24; // Lines in the pattern file
	localparam int TIMEOUT = N_PAT * 40 * CLK_PERIOD;
	localparam int BP_HOLD = 10; // Stall cycles seen before credits resume
	localparam int HOLD_LIMIT = 200; // Give up waiting for in_ready to drop

	logic clk;
	logic rst_n;
	logic in_valid;
	logic [W-1:0] in_gray;
	logic in_ready;
	logic credit_return;
	logic out_valid;
	logic [W-1:0] out_position;
	logic signed [W-1:0] out_delta;
	logic out_glitch;

	logic [W-1:0] pat_mem [4*N_PAT]; // gray, position, delta, glitch per pattern

	int value_errors = 0;
	int protocol_errors = 0;
	int rx_count = 0;    // Samples received so far
	int outstanding = 0; // Receiver slots in use
	int low_cycles = 0;  // Cycles with in_ready low
	int hold_cycles = 0; // Cycles spent withholding
	logic withhold = 1'b1; // No credit returns yet
	logic saw_backpressure = 1'b0;
	logic [31:0] gap_state;
	logic [31:0] credit_state;

	gray_decoder_top #(
		.speed(gray_pkg::FAST)
	) i_dut (
		.clk          (clk),
		.rst_n        (rst_n),
		.in_valid     (in_valid),
		.in_gray      (in_gray),
		.in_ready     (in_ready),
		.credit_return(credit_return),
		.out_valid    (out_valid),
		.out_position (out_position),
		.out_delta    (out_delta),
		.out_glitch   (out_glitch)
	);

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	task automatic check_field(input string name, input logic [W-1:0] expected,
			input logic [W-1:0] actual);
		assert (actual === expected) else begin
			value_errors++;
			$display("[FAIL] %0t %s expected %h actual %h", $time, name, expected, actual);
		end
	endtask

	// Called on a falling edge, returns on the falling edge after acceptance
	task automatic send_word(input logic [W-1:0] g);
		logic taken;
		taken = 1'b0;
		in_valid = 1'b1;
		in_gray = g;
		while (!taken) begin
			taken = in_ready; // Stable mid-cycle, accept on the coming edge
			@(negedge clk);
		end
		in_valid = 1'b0;
	endtask

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD/2) clk = ~clk;
	end

	initial begin
		#(TIMEOUT);
		$display("Timeout with %0d of %0d samples received", rx_count, N_PAT);
		$display("=== FAIL ===");
		$finish;
	end

	// Receiver model on the output link
	always @(negedge clk) begin : receiver
		logic ret;
		if (rst_n === 1'b1) begin
			if (withhold) hold_cycles++;
			if (withhold && !in_ready) low_cycles++; // Pipeline full
			if (withhold && (low_cycles >= BP_HOLD || hold_cycles >= HOLD_LIMIT)) begin
				withhold = 1'b0;
				saw_backpressure = low_cycles >= BP_HOLD;
			end
			ret = 1'b0;
			if (!withhold && outstanding > 0) begin
				credit_state = xorshift(credit_state);
				ret = credit_state[1:0] != 2'b00; // Free a slot most cycles
			end
			if (out_valid === 1'b1) begin
				assert (outstanding < gray_pkg::CREDITS) else begin
					protocol_errors++;
					$display("out_valid fired at %0t with all %0d receiver slots in use",
						$time, gray_pkg::CREDITS);
				end
				assert (rx_count < N_PAT) else begin
					protocol_errors++;
					$display("Extra sample at %0t beyond the %0d patterns", $time, N_PAT);
				end
				if (rx_count < N_PAT) begin
					check_field("out_position", pat_mem[4*rx_count+1], out_position);
					check_field("out_delta", pat_mem[4*rx_count+2], out_delta);
					check_field("out_glitch", pat_mem[4*rx_count+3], W'(out_glitch));
				end
				rx_count++;
				outstanding++;
			end
			if (ret) outstanding--;
			credit_return = ret;
		end
	end

	initial begin
		rst_n = 1'b0;
		in_valid = 1'b0;
		in_gray = '0;
		credit_return = 1'b0;
		gap_state = 32'd53115;
		credit_state = xorshift(32'd53115);
		$readmemh("dv/gray_patterns.txt", pat_mem);
		assert (!$isunknown(pat_mem[4*N_PAT-1])) else begin
			protocol_errors++;
			$display("Pattern file dv/gray_patterns.txt is missing or too short");
		end

		// Idle outputs throughout reset
		repeat (RESET_CYCLES) begin
			@(negedge clk);
			check_field("out_valid", '0, W'(out_valid));
			check_field("in_ready", W'(1), W'(in_ready));
		end
		rst_n = 1'b1;
		@(negedge clk);
		check_field("out_valid", '0, W'(out_valid));
		check_field("in_ready", W'(1), W'(in_ready));

		for (int i = 0; i < N_PAT; i++) begin
			gap_state = xorshift(gap_state);
			repeat (gap_state % 3) @(negedge clk); // Random idle cycles
			send_word(pat_mem[4*i]);
		end

		wait (rx_count == N_PAT);
		repeat (20) @(negedge clk); // Room for duplicates to show up

		assert (saw_backpressure) else begin
			protocol_errors++;
			$display("in_ready never dropped while credits were withheld");
		end
		assert (rx_count == N_PAT) else begin
			protocol_errors++;
			$display("Received %0d samples, expected %0d", rx_count, N_PAT);
		end

		$display("Value errors: %0d, protocol errors: %0d, samples: %0d of %0d",
			value_errors, protocol_errors, rx_count, N_PAT);
		if (value_errors == 0 && protocol_errors == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

/* gray_decoder_top.f */
src/gray_pkg.sv
src/sample_if.sv
src/gray_to_bin.sv
src/position_tracker.sv
src/credit_sender.sv
src/gray_decoder_top.sv
dv/gray_decoder_tb.sv

/* Bender.yml */
package:
  name: gray_decoder

sources:
  - files:
      - src/gray_pkg.sv
      - src/sample_if.sv
      - src/gray_to_bin.sv
      - src/position_tracker.sv
      - src/credit_sender.sv
      - src/gray_decoder_top.sv
  - target: test
    files:
      - dv/gray_decoder_tb.sv

/* dv/gray_patterns.txt */
// Columns: input Gray word, expected position, expected delta mod 4096, expected glitch
// All values hex, one pattern per line, in sending order
000 000 000 0 // All zero, first sample
001 001 001 0
003 002 001 0
001 001 fff 0 // Backward steps
000 000 fff 0
800 fff fff 0 // Wrap 0 to 4095
000 000 001 0 // Wrap 4095 to 0
800 fff fff 0
fff aaa aab 1 // All ones, multi-bit jump
aaa ccc 222 1 // Alternating bits
555 666 99a 1
554 667 001 0 // Forward steps
55c 668 001 0
555 666 ffe 1 // Two bits at once
040 07f a19 1 // Single bit word
0c0 080 001 0
0c1 081 001 0
0c0 080 fff 0
040 07f fff 0
000 000 f81 0
800 fff fff 0
801 ffe fff 0
000 000 002 1 // Wrap with two bits changed
001 001 001 0
